// ==== logic/cordic_macros.svh ====
`ifndef CORDIC_MACROS_SVH
`define CORDIC_MACROS_SVH

// external port widths
`define CORDIC_VEC_W  8
`define CORDIC_ANG_W  9

// internal datapath widths, one degree is 2^11 angle units
`define CORDIC_VEC_PW 24
`define CORDIC_ANG_PW 20

`define CORDIC_ITER   16
`define CORDIC_CNT_W  5
`define CORDIC_ATAN_W 19

// angles beyond the fold limit are mirrored through the half turn
`define CORDIC_FOLD_MAX  90
`define CORDIC_HALF_TURN 180

// inverse CORDIC gain 0.607253 as a sum of right shifts
`define CORDIC_GAIN(v) \
    (((v) >>> 1)  + ((v) >>> 4)  + ((v) >>> 5)  + ((v) >>> 7)  + \
     ((v) >>> 8)  + ((v) >>> 10) + ((v) >>> 11) + ((v) >>> 12) + \
     ((v) >>> 14) + ((v) >>> 17) + ((v) >>> 18) + ((v) >>> 19) + \
     ((v) >>> 21) + ((v) >>> 22))

`endif

// ==== logic/cordic_pkg.sv ====
`default_nettype none
`include "cordic_macros.svh"

package cordic_pkg;

    typedef logic signed [`CORDIC_VEC_W-1:0]  vec_t;
    typedef logic signed [`CORDIC_ANG_W-1:0]  ang_t;
    typedef logic signed [`CORDIC_VEC_PW-1:0] pvec_t;
    typedef logic signed [`CORDIC_ANG_PW-1:0] pang_t;

    // flip flag of a folded rotation angle
    typedef logic rot_side_t;
    // x was negative, vector was mirrored before vectoring
    typedef logic vec_side_t;

    typedef struct packed {
        vec_t x;
        vec_t y;
        ang_t angle;
    } req_t;

    // angle is the residual in rotation mode, the accumulated angle in vectoring mode
    typedef struct packed {
        pvec_t x;
        pvec_t y;
        pang_t angle;
    } seed_t;

    typedef struct packed {
        vec_t x;
        vec_t y;
        ang_t angle;
    } res_t;

    // atan(2^-idx) in degrees, scaled by 2^11
    function automatic logic [`CORDIC_ATAN_W-1:0] atan_entry(
        input logic [`CORDIC_CNT_W-1:0] idx
    );
        logic [`CORDIC_ATAN_W-1:0] val;
        case (idx)
            5'd0:    val = 19'd92160;
            5'd1:    val = 19'd54405;
            5'd2:    val = 19'd28746;
            5'd3:    val = 19'd14592;
            5'd4:    val = 19'd7324;
            5'd5:    val = 19'd3666;
            5'd6:    val = 19'd1833;
            5'd7:    val = 19'd917;
            5'd8:    val = 19'd458;
            5'd9:    val = 19'd229;
            5'd10:   val = 19'd115;
            5'd11:   val = 19'd57;
            5'd12:   val = 19'd29;
            5'd13:   val = 19'd14;
            5'd14:   val = 19'd7;
            5'd15:   val = 19'd4;
            default: val = '0;
        endcase
        return val;
    endfunction

endpackage

`default_nettype wire

// ==== logic/cordic_prescale.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cordic_macros.svh"

module cordic_prescale (
    input  cordic_pkg::req_t      i_req,
    output cordic_pkg::seed_t     o_rot_seed,
    output cordic_pkg::rot_side_t o_rot_side,
    output cordic_pkg::seed_t     o_vec_seed,
    output cordic_pkg::vec_side_t o_vec_side
);

    // one guard bit under the sign leaves room for the CORDIC gain
    localparam int VEC_FRAC = `CORDIC_VEC_PW - `CORDIC_VEC_W - 1;
    localparam int ANG_FRAC = `CORDIC_ANG_PW - `CORDIC_ANG_W;

    localparam cordic_pkg::pang_t FOLD_MAX  = `CORDIC_FOLD_MAX;
    localparam cordic_pkg::pang_t HALF_TURN = `CORDIC_HALF_TURN;

    cordic_pkg::pvec_t x_ext;
    cordic_pkg::pvec_t y_ext;
    cordic_pkg::pvec_t x_gain;
    cordic_pkg::pvec_t y_gain;
    cordic_pkg::pang_t ang_ext;
    cordic_pkg::pang_t ang_fold;
    logic              flip;
    logic              x_neg;

    // input scaling and gain pre-compensation
    always_comb begin
        x_ext  = cordic_pkg::pvec_t'(i_req.x) <<< VEC_FRAC;
        y_ext  = cordic_pkg::pvec_t'(i_req.y) <<< VEC_FRAC;
        x_gain = `CORDIC_GAIN(x_ext);
        y_gain = `CORDIC_GAIN(y_ext);
    end

    // fold the angle into -90..90, output gets negated later
    always_comb begin
        ang_ext  = cordic_pkg::pang_t'(i_req.angle);
        ang_fold = ang_ext;
        flip     = 1'b0;
        if (ang_ext > FOLD_MAX) begin
            ang_fold = ang_ext - HALF_TURN;
            flip     = 1'b1;
        end else if (ang_ext < -FOLD_MAX) begin
            ang_fold = ang_ext + HALF_TURN;
            flip     = 1'b1;
        end
    end

    assign x_neg = i_req.x[`CORDIC_VEC_W-1];

    always_comb begin
        o_rot_seed.x     = x_gain;
        o_rot_seed.y     = y_gain;
        o_rot_seed.angle = ang_fold <<< ANG_FRAC;
        o_rot_side       = flip;
    end

    // mirror into the right half plane for vectoring
    always_comb begin
        if (x_neg) begin
            o_vec_seed.x = -x_gain;
            o_vec_seed.y = -y_gain;
        end else begin
            o_vec_seed.x = x_gain;
            o_vec_seed.y = y_gain;
        end
        o_vec_seed.angle = '0;
        o_vec_side       = x_neg;
    end

endmodule

`default_nettype wire

// ==== logic/cordic_iter_engine.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cordic_macros.svh"

module cordic_iter_engine #(
    parameter bit  VECTORING = 1'b0,
    parameter type side_t    = logic
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  cordic_pkg::seed_t i_seed,
    input  side_t             i_side,
    output logic              o_busy,
    output logic              o_done,
    output cordic_pkg::seed_t o_seed,
    output side_t             o_side
);

    typedef logic [`CORDIC_CNT_W-1:0] cnt_t;
    typedef enum logic [1:0] {S_IDLE, S_ROTATE, S_DONE} state_t;

    localparam cnt_t LAST_ITER = cnt_t'(`CORDIC_ITER - 1);

    state_t            state_q;
    state_t            state_d;
    cnt_t              cnt_q;
    logic              done_q;
    logic              accept;
    cordic_pkg::seed_t seed_q;
    cordic_pkg::seed_t seed_step;
    side_t             side_q;
    cordic_pkg::pvec_t x_cur;
    cordic_pkg::pvec_t y_cur;
    cordic_pkg::pang_t a_cur;
    cordic_pkg::pvec_t x_sh;
    cordic_pkg::pvec_t y_sh;
    cordic_pkg::pang_t atan_k;
    logic              cw;

    // busy stretches over the done cycle so a new start waits for it
    assign o_busy = (state_q != S_IDLE) || done_q;
    assign accept = i_start && !o_busy;

    // one micro-rotation per cycle
    always_comb begin
        x_cur  = seed_q.x;
        y_cur  = seed_q.y;
        a_cur  = seed_q.angle;
        x_sh   = x_cur >>> cnt_q;
        y_sh   = y_cur >>> cnt_q;
        atan_k = {1'b0, cordic_pkg::atan_entry(cnt_q)};
        // rotation chases the residual angle, vectoring chases y
        cw = VECTORING ? !y_cur[`CORDIC_VEC_PW-1] : a_cur[`CORDIC_ANG_PW-1];
        if (cw) begin
            seed_step.x     = x_cur + y_sh;
            seed_step.y     = y_cur - x_sh;
            seed_step.angle = a_cur + atan_k;
        end else begin
            seed_step.x     = x_cur - y_sh;
            seed_step.y     = y_cur + x_sh;
            seed_step.angle = a_cur - atan_k;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:   if (accept) state_d = S_ROTATE;
            S_ROTATE: if (cnt_q == LAST_ITER) state_d = S_DONE;
            S_DONE:   state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == S_DONE);
            if (accept) begin
                cnt_q <= '0;
            end else if (state_q == S_ROTATE) begin
                cnt_q <= cnt_q + cnt_t'(1);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            seed_q <= i_seed;
            side_q <= i_side;
        end else if (state_q == S_ROTATE) begin
            seed_q <= seed_step;
        end
    end

    assign o_done = done_q;
    assign o_seed = seed_q;
    assign o_side = side_q;

endmodule

`default_nettype wire

// ==== logic/cordic_result_merge.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cordic_macros.svh"

module cordic_result_merge (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_rot_done,
    input  logic                  i_vec_done,
    input  cordic_pkg::seed_t     i_rot_seed,
    input  cordic_pkg::seed_t     i_vec_seed,
    input  cordic_pkg::rot_side_t i_rot_side,
    input  cordic_pkg::vec_side_t i_vec_side,
    output logic                  o_done,
    output cordic_pkg::res_t      o_res
);

    localparam int VEC_FRAC = `CORDIC_VEC_PW - `CORDIC_VEC_W - 1;
    localparam int ANG_FRAC = `CORDIC_ANG_PW - `CORDIC_ANG_W;

    localparam cordic_pkg::pvec_t VEC_MAX   = (1 <<< (`CORDIC_VEC_W - 1)) - 1;
    localparam cordic_pkg::pvec_t VEC_MIN   = -(1 <<< (`CORDIC_VEC_W - 1));
    localparam cordic_pkg::pvec_t VEC_HALF  = 1 <<< (VEC_FRAC - 1);
    localparam cordic_pkg::pang_t ANG_HALF  = 1 <<< (ANG_FRAC - 1);
    localparam cordic_pkg::pang_t HALF_TURN = `CORDIC_HALF_TURN;

    cordic_pkg::res_t  res_d;
    cordic_pkg::pang_t ang_acc;
    cordic_pkg::pang_t ang_rnd;
    cordic_pkg::pang_t ang_fix;
    logic              rot_seen_q;
    logic              vec_seen_q;
    logic              both_done;

    // round to the external width, undo the fold, then saturate
    function automatic cordic_pkg::vec_t scale_down(
        input cordic_pkg::pvec_t v,
        input logic              neg
    );
        cordic_pkg::pvec_t r;
        r = (v + VEC_HALF) >>> VEC_FRAC;
        if (neg) begin
            r = -r;
        end
        if (r > VEC_MAX) begin
            r = VEC_MAX;
        end else if (r < VEC_MIN) begin
            r = VEC_MIN;
        end
        return cordic_pkg::vec_t'(r);
    endfunction

    always_comb begin
        ang_acc = i_vec_seed.angle;
        ang_rnd = (ang_acc + ANG_HALF) >>> ANG_FRAC;
        ang_fix = ang_rnd;
        // vector was mirrored, move back by half a turn
        if (i_vec_side) begin
            ang_fix = ang_rnd[`CORDIC_ANG_PW-1] ? ang_rnd + HALF_TURN : ang_rnd - HALF_TURN;
        end
        res_d.x     = scale_down(i_rot_seed.x, i_rot_side);
        res_d.y     = scale_down(i_rot_seed.y, i_rot_side);
        res_d.angle = cordic_pkg::ang_t'(ang_fix);
    end

    assign both_done = (rot_seen_q || i_rot_done) && (vec_seen_q || i_vec_done);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rot_seen_q <= 1'b0;
            vec_seen_q <= 1'b0;
            o_done     <= 1'b0;
            o_res      <= '0;
        end else begin
            o_done <= both_done;
            if (both_done) begin
                o_res      <= res_d;
                rot_seen_q <= 1'b0;
                vec_seen_q <= 1'b0;
            end else begin
                rot_seen_q <= rot_seen_q || i_rot_done;
                vec_seen_q <= vec_seen_q || i_vec_done;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cordic_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cordic_top (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  cordic_pkg::req_t i_req,
    output logic             o_busy,
    output logic             o_done,
    output cordic_pkg::res_t o_res
);

    cordic_pkg::seed_t     rot_seed_in;
    cordic_pkg::seed_t     vec_seed_in;
    cordic_pkg::rot_side_t rot_side_in;
    cordic_pkg::vec_side_t vec_side_in;
    cordic_pkg::seed_t     rot_seed_out;
    cordic_pkg::seed_t     vec_seed_out;
    cordic_pkg::rot_side_t rot_side_out;
    cordic_pkg::vec_side_t vec_side_out;
    logic                  rot_done;
    logic                  vec_done;

    cordic_prescale u_prescale (
        .i_req      (i_req),
        .o_rot_seed (rot_seed_in),
        .o_rot_side (rot_side_in),
        .o_vec_seed (vec_seed_in),
        .o_vec_side (vec_side_in)
    );

    // both engines run in lockstep, rotation one reports busy
    cordic_iter_engine #(
        .VECTORING (1'b0),
        .side_t    (cordic_pkg::rot_side_t)
    ) u_rot_engine (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_seed  (rot_seed_in),
        .i_side  (rot_side_in),
        .o_busy  (o_busy),
        .o_done  (rot_done),
        .o_seed  (rot_seed_out),
        .o_side  (rot_side_out)
    );

    cordic_iter_engine #(
        .VECTORING (1'b1),
        .side_t    (cordic_pkg::vec_side_t)
    ) u_vec_engine (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_seed  (vec_seed_in),
        .i_side  (vec_side_in),
        .o_busy  (),
        .o_done  (vec_done),
        .o_seed  (vec_seed_out),
        .o_side  (vec_side_out)
    );

    cordic_result_merge u_merge (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rot_done (rot_done),
        .i_vec_done (vec_done),
        .i_rot_seed (rot_seed_out),
        .i_vec_seed (vec_seed_out),
        .i_rot_side (rot_side_out),
        .i_vec_side (vec_side_out),
        .o_done     (o_done),
        .o_res      (o_res)
    );

endmodule

`default_nettype wire

// ==== dv/cordic_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module cordic_sva (
    input logic             i_clk,
    input logic             i_rst_n,
    input logic             i_start,
    input logic             i_busy,
    input logic             i_done,
    input cordic_pkg::res_t i_res
);

    // start pulses the engines actually take
    logic        accepted;
    int unsigned fail_cnt = 0;

    assign accepted = i_start && !i_busy;

    // first edge after reset release
    reset_idle_a: assert property (@(posedge i_clk)
        $rose(i_rst_n) |-> !i_busy && !i_done && i_res == '0)
    else begin
        fail_cnt++;
        $error("busy, done or result not cleared by reset");
    end

    busy_rise_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        accepted |=> i_busy)
    else begin
        fail_cnt++;
        $error("o_busy not raised after an accepted start");
    end

    // accept edge plus 18 edges, seen one sample later
    done_latency_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        accepted |-> ##19 i_done)
    else begin
        fail_cnt++;
        $error("o_done missing 18 edges after an accepted start");
    end

    done_source_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done |-> $past(accepted, 19))
    else begin
        fail_cnt++;
        $error("o_done without a matching accepted start");
    end

    done_pulse_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done |=> !i_done)
    else begin
        fail_cnt++;
        $error("o_done high for more than one cycle");
    end

    busy_fall_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_busy) |-> i_done)
    else begin
        fail_cnt++;
        $error("o_busy dropped before o_done");
    end

    res_hold_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_done |-> $stable(i_res))
    else begin
        fail_cnt++;
        $error("o_res changed without o_done");
    end

endmodule

bind cordic_top cordic_sva u_sva (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_start (i_start),
    .i_busy  (o_busy),
    .i_done  (o_done),
    .i_res   (o_res)
);

`default_nettype wire

// ==== dv/cordic_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cordic_tb;

    localparam real PI           = 3.14159265358979;
    localparam int  DONE_TIMEOUT = 40;

    logic             clk;
    logic             rst_n;
    logic             start;
    cordic_pkg::req_t req;
    logic             busy;
    logic             done;
    cordic_pkg::res_t res;

    cordic_top i_dut (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_start (start),
        .i_req   (req),
        .o_busy  (busy),
        .o_done  (done),
        .o_res   (res)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // timing assertions count their failures in the bound checker
    always @(negedge clk) begin
        if (i_dut.u_sva.fail_cnt != 0) begin
            $display("a timing assertion in cordic_sva failed");
            $display("ERRORS FOUND");
            $fatal(1, "timing check failed");
        end
    end

    function automatic int round_real(input real v);
        return $rtoi(v >= 0.0 ? v + 0.5 : v - 0.5);
    endfunction

    function automatic int clamp_vec(input int v);
        if (v > 127) begin
            return 127;
        end
        if (v < -128) begin
            return -128;
        end
        return v;
    endfunction

    task automatic report_value(input string name, input int expected, input int actual);
        $display("** Error at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "value check failed");
    endtask

    task automatic report_event(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "%s", what);
    endtask

    // request is valid only while start is high
    task automatic pulse_start(input int x, input int y, input int a);
        @(posedge clk);
        #2;
        req.x     = cordic_pkg::vec_t'(x);
        req.y     = cordic_pkg::vec_t'(y);
        req.angle = cordic_pkg::ang_t'(a);
        start     = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        req   = '1;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (cycles == DONE_TIMEOUT) begin
                report_event("timeout, o_done did not rise within 40 cycles");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic check_result(input int x, input int y, input int a);
        real rad;
        real ang_exp;
        real ang_err;
        int  x_exp;
        int  y_exp;
        rad   = a * PI / 180.0;
        x_exp = clamp_vec(round_real(x * $cos(rad) - y * $sin(rad)));
        y_exp = clamp_vec(round_real(x * $sin(rad) + y * $cos(rad)));
        x_ok: assert (res.x >= x_exp - 2 && res.x <= x_exp + 2)
            else report_value("o_res.x", x_exp, res.x);
        y_ok: assert (res.y >= y_exp - 2 && res.y <= y_exp + 2)
            else report_value("o_res.y", y_exp, res.y);
        if (x * x + y * y >= 256) begin
            ang_exp = $atan2(y, x) * 180.0 / PI;
            ang_err = res.angle - ang_exp;
            // 180 and -180 point the same way
            if (ang_err > 180.0) begin
                ang_err = ang_err - 360.0;
            end else if (ang_err < -180.0) begin
                ang_err = ang_err + 360.0;
            end
            ang_ok: assert (ang_err >= -1.0 && ang_err <= 1.0)
                else report_value("o_res.angle", round_real(ang_exp), res.angle);
        end
    endtask

    task automatic run_request(input int x, input int y, input int a);
        pulse_start(x, y, a);
        wait_done();
        check_result(x, y, a);
    endtask

    initial begin
        int x;
        int y;
        int a;
        int q;
        int mag;
        int oth;
        void'($urandom(98));
        rst_n = 1'b0;
        start = 1'b0;
        req   = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // random rotations over the whole circle
        repeat (40) begin
            x = int'($urandom % 161) - 80;
            y = int'($urandom % 161) - 80;
            a = int'($urandom % 361) - 180;
            run_request(x, y, a);
        end

        // at and beyond the fold limit
        run_request(60, 20, 90);
        run_request(-45, 70, 91);
        run_request(50, -35, -91);
        run_request(-70, -30, 180);
        run_request(25, 75, -180);

        // vectoring in all four quadrants, one component at least 16
        for (q = 0; q < 4; q++) begin
            repeat (6) begin
                mag = 16 + int'($urandom % 70);
                oth = int'($urandom % 86);
                x   = ($urandom % 2 == 0) ? mag : oth;
                y   = (x == mag) ? oth : mag;
                if (q == 1 || q == 2) begin
                    x = -x;
                end
                if (q >= 2) begin
                    y = -y;
                end
                a = int'($urandom % 361) - 180;
                run_request(x, y, a);
            end
        end
        // negative x axis, angle of +-180
        run_request(-60, 0, 45);

        // second start in the middle of a run must be dropped
        pulse_start(40, -30, 60);
        repeat (5) @(posedge clk);
        pulse_start(-70, 50, -120);
        wait_done();
        check_result(40, -30, 60);
        repeat (25) begin
            @(negedge clk);
            no_extra_done: assert (done == 1'b0)
                else report_event("o_done rose for a start that came while busy");
        end

        if (i_dut.u_sva.fail_cnt != 0) begin
            $display("a timing assertion in cordic_sva failed");
            $display("ERRORS FOUND");
            $fatal(1, "timing check failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/cordic_pkg.sv
logic/cordic_prescale.sv
logic/cordic_iter_engine.sv
logic/cordic_result_merge.sv
logic/cordic_top.sv
dv/cordic_sva.sv
dv/cordic_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the CORDIC testbench with Verilator and run it
# exit status is nonzero when the build fails or the testbench stops with $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f vlog.f --top-module cordic_tb -o cordic_sim \
    && ./obj_dir/cordic_sim +verilator+error+limit+100 \
    || { echo "cordic simulation failed"; exit 1; }
